//--- Bender.yml
package:
  name: hangman

sources:
  - include_dirs:
      - design
    files:
      - design/gamePkg.sv
      - design/wbGameRegs.sv
      - design/wordShifter.sv
      - design/letterScanner.sv
      - design/scoreKeeper.sv
      - design/lampDriver.sv
      - design/hangmanTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/hangmanTb.sv

//--- design/gamePkg.sv
`include "game_defs.svh"

package gamePkg;

    typedef logic [`LETTER_W-1:0] letterT;
    typedef logic [`WORD_LEN-1:0] maskT;
    typedef logic [2:0]           countT;

    typedef enum logic [2:0] {
        scanIdle,
        scanPos0,
        scanPos1,
        scanPos2,
        scanPos3,
        scanPos4,
        scanResult
    } scanStateT;

    // Listed last field first, so revealed sits at bit 0 of STATUS.
    typedef struct packed {
        logic  busy;
        logic  lost;
        logic  won;
        logic  wordReady;
        countT misses;
        countT hits;
        maskT  revealed;
    } gameStatusT;

endpackage

//--- design/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Shape of the game.
`define WORD_LEN      5
`define LETTER_W      8
`define MAX_MISTAKES  6

// Lamp on-time after one hit or miss, in clock cycles.
`define LAMP_HOLD     16

// Register map, word addresses.
`define ADR_CTRL      2'd0
`define ADR_WORD      2'd1
`define ADR_GUESS     2'd2
`define ADR_STATUS    2'd3

`endif

//--- design/hangmanTop.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module hangmanTop (
    input  logic        clk,
    input  logic        nRst,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic [1:0]  wbAdr,
    input  logic [31:0] wbDatIn,
    output logic [31:0] wbDatOut,
    output logic        wbAck,
    output logic        green,
    output logic        red
);
    import gamePkg::*;

    logic                    clearWord;
    logic                    loadLetter;
    letterT                  newLetter;
    letterT [`WORD_LEN-1:0] word;
    logic                    wordReady;
    logic                    scanStart;
    letterT                  guess;
    logic                    scanBusy;
    logic                    scanDone;
    maskT                    matchMask;
    logic                    hitPulse;
    logic                    missPulse;
    gameStatusT              scoreStatus;
    gameStatusT              busStatus;

    // Scanner activity goes into the busy bit of STATUS.
    always_comb begin
        busStatus      = scoreStatus;
        busStatus.busy = scanBusy;
    end

    wbGameRegs regs (
        .clk        (clk),
        .nRst       (nRst),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAdr      (wbAdr),
        .wbDatIn    (wbDatIn),
        .status     (busStatus),
        .scanBusy   (scanBusy),
        .wbDatOut   (wbDatOut),
        .wbAck      (wbAck),
        .clearWord  (clearWord),
        .loadLetter (loadLetter),
        .newLetter  (newLetter),
        .scanStart  (scanStart),
        .guess      (guess)
    );

    wordShifter shifter (
        .clk        (clk),
        .nRst       (nRst),
        .clearWord  (clearWord),
        .loadLetter (loadLetter),
        .newLetter  (newLetter),
        .word       (word),
        .wordReady  (wordReady)
    );

    letterScanner scanner (
        .clk       (clk),
        .nRst      (nRst),
        .scanStart (scanStart),
        .guess     (guess),
        .word      (word),
        .busy      (scanBusy),
        .scanDone  (scanDone),
        .matchMask (matchMask)
    );

    scoreKeeper keeper (
        .clk       (clk),
        .nRst      (nRst),
        .clearWord (clearWord),
        .scanDone  (scanDone),
        .matchMask (matchMask),
        .wordReady (wordReady),
        .status    (scoreStatus),
        .hitPulse  (hitPulse),
        .missPulse (missPulse)
    );

    lampDriver lamps (
        .clk       (clk),
        .nRst      (nRst),
        .hitPulse  (hitPulse),
        .missPulse (missPulse),
        .green     (green),
        .red       (red)
    );

endmodule

//--- design/lampDriver.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module lampDriver (
    input  logic clk,
    input  logic nRst,
    input  logic hitPulse,
    input  logic missPulse,
    output logic green,
    output logic red
);
    localparam int HoldW = $clog2(`LAMP_HOLD + 1);

    // Index 0 drives green, index 1 drives red.
    logic [1:0]            pulse;
    logic [1:0][HoldW-1:0] holdCnt;

    // A miss beats a hit in the same cycle.
    assign pulse = {missPulse, hitPulse && !missPulse};

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            holdCnt <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (pulse[i]) begin
                    holdCnt[i] <= HoldW'(`LAMP_HOLD);
                end else if (holdCnt[i] != '0) begin
                    holdCnt[i] <= holdCnt[i] - 1'b1;
                end
            end
        end
    end

    assign green = (holdCnt[0] != '0);
    assign red   = (holdCnt[1] != '0);

endmodule

//--- design/letterScanner.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module letterScanner (
    input  logic                             clk,
    input  logic                             nRst,
    input  logic                             scanStart,
    input  gamePkg::letterT                  guess,
    input  gamePkg::letterT [`WORD_LEN-1:0] word,
    output logic                             busy,
    output logic                             scanDone,
    output gamePkg::maskT                    matchMask
);
    import gamePkg::*;

    scanStateT  state;
    scanStateT  nextState;
    letterT     guessReg;
    logic [2:0] pos;
    logic       posValid;

    always_comb begin
        nextState = state;
        posValid  = 1'b1;
        pos       = 3'd0;
        case (state)
            scanIdle: begin
                posValid = 1'b0;
                if (scanStart) begin
                    nextState = scanPos0;
                end
            end
            scanPos0: begin
                pos       = 3'd0;
                nextState = scanPos1;
            end
            scanPos1: begin
                pos       = 3'd1;
                nextState = scanPos2;
            end
            scanPos2: begin
                pos       = 3'd2;
                nextState = scanPos3;
            end
            scanPos3: begin
                pos       = 3'd3;
                nextState = scanPos4;
            end
            scanPos4: begin
                pos       = 3'd4;
                nextState = scanResult;
            end
            default: begin
                posValid  = 1'b0;
                nextState = scanIdle;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= scanIdle;
        end else begin
            state <= nextState;
        end
    end

    // One position compared per cycle.
    always_ff @(posedge clk) begin
        if (state == scanIdle && scanStart) begin
            guessReg  <= guess;
            matchMask <= '0;
        end else if (posValid) begin
            matchMask[pos] <= (word[pos] == guessReg);
        end
    end

    assign busy     = (state != scanIdle);
    assign scanDone = (state == scanResult);

    noStartWhileBusy: assert property (@(posedge clk) disable iff (!nRst)
        scanStart |-> !busy)
        else $error("scanStart arrived while the scanner was busy");

endmodule

//--- design/scoreKeeper.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module scoreKeeper (
    input  logic                clk,
    input  logic                nRst,
    input  logic                clearWord,
    input  logic                scanDone,
    input  gamePkg::maskT       matchMask,
    input  logic                wordReady,
    output gamePkg::gameStatusT status,
    output logic                hitPulse,
    output logic                missPulse
);
    import gamePkg::*;

    maskT  revealed;
    maskT  nextRevealed;
    countT hits;
    countT misses;
    countT nextMisses;
    logic  won;
    logic  lost;
    logic  isHit;

    assign isHit        = |matchMask;
    assign nextRevealed = revealed | matchMask;
    assign nextMisses   = misses + 3'd1;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            revealed  <= '0;
            hits      <= '0;
            misses    <= '0;
            won       <= 1'b0;
            lost      <= 1'b0;
            hitPulse  <= 1'b0;
            missPulse <= 1'b0;
        end else if (clearWord) begin
            revealed  <= '0;
            hits      <= '0;
            misses    <= '0;
            won       <= 1'b0;
            lost      <= 1'b0;
            hitPulse  <= 1'b0;
            missPulse <= 1'b0;
        end else begin
            hitPulse  <= scanDone && isHit;
            missPulse <= scanDone && !isHit;
            if (scanDone && isHit) begin
                revealed <= nextRevealed;
                // hits saturates at 7.
                if (hits != '1) begin
                    hits <= hits + 3'd1;
                end
                won <= &nextRevealed;
            end else if (scanDone) begin
                misses <= nextMisses;
                lost   <= (nextMisses == countT'(`MAX_MISTAKES));
            end
        end
    end

    always_comb begin
        status.revealed  = revealed;
        status.hits      = hits;
        status.misses    = misses;
        status.wordReady = wordReady;
        status.won       = won;
        status.lost      = lost;
        status.busy      = 1'b0;
    end

    wonLostExclusive: assert property (@(posedge clk) disable iff (!nRst)
        !(won && lost))
        else $error("won and lost both set");

endmodule

//--- design/wbGameRegs.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module wbGameRegs (
    input  logic                clk,
    input  logic                nRst,
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  logic [1:0]          wbAdr,
    input  logic [31:0]         wbDatIn,
    input  gamePkg::gameStatusT status,
    input  logic                scanBusy,
    output logic [31:0]         wbDatOut,
    output logic                wbAck,
    output logic                clearWord,
    output logic                loadLetter,
    output gamePkg::letterT     newLetter,
    output logic                scanStart,
    output gamePkg::letterT     guess
);
    import gamePkg::*;

    logic        request;
    logic        guessWrite;
    logic        wordWrite;
    logic        accept;
    logic        gameOpen;
    logic [31:0] readData;

    // The request is ignored during the ack cycle, before the master drops stb.
    assign request    = wbCyc && wbStb && !wbAck;
    assign guessWrite = wbWe && (wbAdr == `ADR_GUESS);
    assign wordWrite  = wbWe && (wbAdr == `ADR_WORD);

    // A guess waits here until the scanner is idle again.
    assign accept   = request && !(guessWrite && (scanBusy || scanStart));
    assign gameOpen = status.wordReady && !status.won && !status.lost;

    always_comb begin
        case (wbAdr)
            `ADR_STATUS: readData = {{(32 - $bits(gameStatusT)){1'b0}}, status};
            `ADR_GUESS:  readData = {{(32 - `LETTER_W){1'b0}}, guess};
            default:     readData = '0;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wbAck      <= 1'b0;
            clearWord  <= 1'b0;
            loadLetter <= 1'b0;
            scanStart  <= 1'b0;
        end else begin
            wbAck      <= accept;
            clearWord  <= accept && wbWe && (wbAdr == `ADR_CTRL) && wbDatIn[0];
            loadLetter <= accept && wordWrite;
            scanStart  <= accept && guessWrite && gameOpen;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && wordWrite) begin
            newLetter <= wbDatIn[`LETTER_W-1:0];
        end
        if (accept && guessWrite) begin
            guess <= wbDatIn[`LETTER_W-1:0];
        end
        if (accept && !wbWe) begin
            wbDatOut <= readData;
        end
    end

    ackSingleCycle: assert property (@(posedge clk) disable iff (!nRst)
        wbAck |=> !wbAck)
        else $error("wbAck held high for two cycles");

endmodule

//--- design/wordShifter.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module wordShifter (
    input  logic                             clk,
    input  logic                             nRst,
    input  logic                             clearWord,
    input  logic                             loadLetter,
    input  gamePkg::letterT                  newLetter,
    output gamePkg::letterT [`WORD_LEN-1:0] word,
    output logic                             wordReady
);
    localparam int CountW = $clog2(`WORD_LEN + 1);

    logic [CountW-1:0] loadCount;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            loadCount <= '0;
        end else if (clearWord) begin
            loadCount <= '0;
        end else if (loadLetter && !wordReady) begin
            loadCount <= loadCount + 1'b1;
        end
    end

    // Letters enter at the top, so the first one loaded ends up in slot 0.
    always_ff @(posedge clk) begin
        if (clearWord) begin
            word <= '0;
        end else if (loadLetter) begin
            word <= {newLetter, word[`WORD_LEN-1:1]};
        end
    end

    assign wordReady = (loadCount == CountW'(`WORD_LEN));

endmodule

//--- tb.f
+incdir+design
design/gamePkg.sv
design/wbGameRegs.sv
design/wordShifter.sv
design/letterScanner.sv
design/scoreKeeper.sv
design/lampDriver.sv
design/hangmanTop.sv
testbench/hangmanTb.sv

//--- testbench/hangmanTb.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module hangmanTb;
    import gamePkg::*;

    localparam int ClkPeriod     = 8;
    localparam int ResetCycles   = 10;
    localparam int NumTests      = 6;
    localparam int CyclesPerTest = 200;
    localparam int AckLimit      = 64;

    logic        clk;
    logic        nRst;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [1:0]  wbAdr;
    logic [31:0] wbDatIn;
    logic [31:0] wbDatOut;
    logic        wbAck;
    logic        green;
    logic        red;

    int          errorCount;
    int          checkCount;
    int          lastAckWait;
    int unsigned seedVal;

    // Reference model of the game.
    letterT modelWord[$];
    maskT   modelRevealed;
    countT  modelHits;
    countT  modelMisses;
    logic   modelWon;
    logic   modelLost;

    hangmanTop dut (
        .clk      (clk),
        .nRst     (nRst),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatIn  (wbDatIn),
        .wbDatOut (wbDatOut),
        .wbAck    (wbAck),
        .green    (green),
        .red      (red)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    initial begin
        #((ResetCycles + NumTests * CyclesPerTest) * ClkPeriod);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checkCount++;
        assert (cond) else begin
            errorCount++;
            $display("%s", what);
        end
    endtask

    // Single-beat access, the master holds the request until ack.
    task automatic wbTransfer(input logic we, input logic [1:0] adr, input logic [31:0] data,
                              output logic [31:0] rdata);
        @(posedge clk);
        wbCyc   <= 1'b1;
        wbStb   <= 1'b1;
        wbWe    <= we;
        wbAdr   <= adr;
        wbDatIn <= data;
        lastAckWait = 0;
        do begin
            @(negedge clk);
            lastAckWait++;
        end while (!wbAck && lastAckWait < AckLimit);
        rdata = wbDatOut;
        checkTrue(wbAck === 1'b1, $sformatf("No ack for the access to address %0d", adr));
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
    endtask

    task automatic wbWrite(input logic [1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wbTransfer(1'b1, adr, data, unused);
    endtask

    task automatic wbRead(input logic [1:0] adr, output logic [31:0] data);
        wbTransfer(1'b0, adr, 32'h0, data);
    endtask

    // STATUS fields from bit 0: revealed, hits, misses, wordReady, won, lost, busy.
    function automatic logic [31:0] expectedStatus();
        logic ready;
        ready = (modelWord.size() == `WORD_LEN);
        return {17'd0, 1'b0, modelLost, modelWon, ready, modelMisses, modelHits, modelRevealed};
    endfunction

    task automatic clearModel();
        modelWord.delete();
        modelRevealed = '0;
        modelHits     = '0;
        modelMisses   = '0;
        modelWon      = 1'b0;
        modelLost     = 1'b0;
    endtask

    task automatic modelGuess(input letterT letter);
        maskT hitMask;
        hitMask = '0;
        if (modelWord.size() == `WORD_LEN && !modelWon && !modelLost) begin
            for (int i = 0; i < `WORD_LEN; i++) begin
                if (modelWord[i] == letter) begin
                    hitMask[i] = 1'b1;
                end
            end
            if (hitMask != '0) begin
                modelRevealed |= hitMask;
                if (modelHits != 3'd7) begin
                    modelHits++;
                end
                modelWon = (modelRevealed == '1);
            end else begin
                modelMisses++;
                modelLost = (modelMisses == `MAX_MISTAKES);
            end
        end
    endtask

    task automatic newGame();
        wbWrite(`ADR_CTRL, 32'h1);
        clearModel();
    endtask

    // Byte i of letters is the i-th letter loaded.
    task automatic loadWord(input logic [`WORD_LEN*`LETTER_W-1:0] letters);
        letterT dropped;
        for (int i = 0; i < `WORD_LEN; i++) begin
            wbWrite(`ADR_WORD, {24'd0, letters[8*i +: 8]});
            modelWord.push_back(letters[8*i +: 8]);
            if (modelWord.size() > `WORD_LEN) begin
                dropped = modelWord.pop_front();
            end
        end
    endtask

    function automatic letterT randomLetter();
        int unsigned offset;
        offset = $urandom % 26;
        return letterT'(8'h41 + offset);
    endfunction

    function automatic logic [`WORD_LEN*`LETTER_W-1:0] randomWord();
        logic [`WORD_LEN*`LETTER_W-1:0] letters;
        for (int i = 0; i < `WORD_LEN; i++) begin
            letters[8*i +: 8] = randomLetter();
        end
        return letters;
    endfunction

    task automatic checkStatus();
        logic [31:0] status;
        wbRead(`ADR_STATUS, status);
        checkEqual("STATUS", status, expectedStatus());
    endtask

    task automatic playGuess(input letterT letter);
        wbWrite(`ADR_GUESS, {24'd0, letter});
        modelGuess(letter);
        // Scan plus score update, 8 cycles after the ack.
        repeat (8) @(posedge clk);
        checkStatus();
    endtask

    task automatic resetAndIdle();
        checkStatus();
        @(negedge clk);
        checkEqual("green", green, 1'b0);
        checkEqual("red", red, 1'b0);
        // No word yet, so this guess is dropped.
        playGuess(8'h41);
    endtask

    task automatic wordLoadHits();
        loadWord("LEVEL");
        checkStatus();
        playGuess(8'h45);
        @(negedge clk);
        checkEqual("green", green, 1'b1);
        checkEqual("red", red, 1'b0);
    endtask

    task automatic missesToLoss();
        for (int i = 0; i < `MAX_MISTAKES; i++) begin
            playGuess(letterT'(8'h30 + i));
            @(negedge clk);
            checkEqual("red", red, 1'b1);
        end
        playGuess(8'h4C);
    endtask

    task automatic winGame();
        logic [`WORD_LEN*`LETTER_W-1:0] letters;
        logic [31:0]                    status;
        logic                           seen;
        int                             distinct;
        distinct = 0;
        letters  = randomWord();
        newGame();
        loadWord(letters);
        for (int i = 0; i < `WORD_LEN; i++) begin
            seen = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (letters[8*j +: 8] == letters[8*i +: 8]) begin
                    seen = 1'b1;
                end
            end
            if (!seen) begin
                distinct++;
                playGuess(letters[8*i +: 8]);
            end
        end
        wbRead(`ADR_STATUS, status);
        checkEqual("STATUS.revealed", status[4:0], 5'h1F);
        checkEqual("STATUS.hits", status[7:5], distinct);
        checkEqual("STATUS.won", status[12], 1'b1);
    endtask

    task automatic backPressure();
        logic [`WORD_LEN*`LETTER_W-1:0] letters;
        letters = randomWord();
        newGame();
        loadWord(letters);
        wbWrite(`ADR_GUESS, {24'd0, letters[23:16]});
        wbWrite(`ADR_GUESS, 32'h30);
        // Request from cycle 2 of the first scan, scanner idle again in cycle 7.
        checkTrue(lastAckWait >= 7,
                  $sformatf("Second GUESS acked after %0d cycles, before the scan ended",
                            lastAckWait));
        modelGuess(letters[23:16]);
        modelGuess(8'h30);
        repeat (8) @(posedge clk);
        checkStatus();
    endtask

    task automatic newGameReplay();
        logic [`WORD_LEN*`LETTER_W-1:0] letters;
        logic [31:0]                    status;
        int unsigned                    pos;
        newGame();
        wbRead(`ADR_STATUS, status);
        checkEqual("STATUS after CTRL", status, 32'h0);
        letters = randomWord();
        loadWord(letters);
        for (int i = 0; i < 8; i++) begin
            pos = $urandom % `WORD_LEN;
            if ($urandom % 2) begin
                playGuess(letters[8*pos +: 8]);
            end else begin
                playGuess(randomLetter());
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        nRst       = 1'b0;
        wbCyc      = 1'b0;
        wbStb      = 1'b0;
        wbWe       = 1'b0;
        wbAdr      = '0;
        wbDatIn    = '0;
        errorCount = 0;
        checkCount = 0;
        seedVal    = $urandom(70);
        clearModel();
        repeat (ResetCycles) @(posedge clk);
        nRst <= 1'b1;

        resetAndIdle();
        wordLoadHits();
        missesToLoss();
        winGame();
        backPressure();
        newGameReplay();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
